//--- Bender.yml
package:
  name: eth_axis_tx_64

sources:
  # RTL in compile order
  - hdl/eth_tx_pkg.sv
  - hdl/axis_if.sv
  - hdl/eth_hdr_insert.sv
  - hdl/axis_out_reg.sv
  - hdl/eth_axis_tx_64.sv

  # testbench
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/eth_axis_tx_64_checker.sv
      - verification/eth_axis_tx_64_tb.sv

//--- compile.f
hdl/eth_tx_pkg.sv
hdl/axis_if.sv
hdl/eth_hdr_insert.sv
hdl/axis_out_reg.sv
hdl/eth_axis_tx_64.sv
verification/tb_clk_gen.sv
verification/eth_axis_tx_64_checker.sv
verification/eth_axis_tx_64_tb.sv

//--- hdl/axis_if.sv
// 64-bit ready/valid stream between inserter and output register
// source and sink modports, with the early ready of the sink
`timescale 1ns/10ps

interface axis_if;

    logic [eth_tx_pkg::DATA_W-1:0] tdata;
    logic [eth_tx_pkg::KEEP_W-1:0] tkeep;
    logic                          tvalid;
    logic                          tlast;
    logic                          tuser;
    // registered ready, source pushes only while high
    logic                          tready;
    // value tready takes on the next cycle
    logic                          tready_early;

    modport src (
        output tdata,
        output tkeep,
        output tvalid,
        output tlast,
        output tuser,
        input  tready,
        input  tready_early
    );

    modport snk (
        input  tdata,
        input  tkeep,
        input  tvalid,
        input  tlast,
        input  tuser,
        output tready,
        output tready_early
    );

endinterface

//--- hdl/axis_out_reg.sv
// output register stage for the 64-bit stream
// output slot plus holding slot, registered and early ready
`timescale 1ns/10ps

module axis_out_reg (
    input  logic                          clk,
    input  logic                          rst,
    axis_if.snk                           s,
    output logic [eth_tx_pkg::DATA_W-1:0] m_tdata,
    output logic [eth_tx_pkg::KEEP_W-1:0] m_tkeep,
    output logic                          m_tvalid,
    input  logic                          m_tready,
    output logic                          m_tlast,
    output logic                          m_tuser
);

    logic [eth_tx_pkg::DATA_W-1:0] hold_data;
    logic [eth_tx_pkg::KEEP_W-1:0] hold_keep;
    logic                          hold_valid;
    logic                          hold_last;
    logic                          hold_user;

    // room next cycle if draining, both slots empty,
    // or holding slot empty and nothing pushed now
    assign s.tready_early = m_tready || (!hold_valid && !m_tvalid) ||
                            (!hold_valid && !s.tvalid);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s.tready <= 1'b0;
            m_tvalid <= 1'b0;
            hold_valid <= 1'b0;
        end else begin
            s.tready <= s.tready_early;
            if (s.tready) begin
                if (m_tready || !m_tvalid) begin
                    m_tvalid <= s.tvalid;
                end else begin
                    hold_valid <= s.tvalid;
                end
            end else if (m_tready) begin
                m_tvalid <= hold_valid;
                hold_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s.tready) begin
            if (m_tready || !m_tvalid) begin
                m_tdata <= s.tdata;
                m_tkeep <= s.tkeep;
                m_tlast <= s.tlast;
                m_tuser <= s.tuser;
            end else begin
                hold_data <= s.tdata;
                hold_keep <= s.tkeep;
                hold_last <= s.tlast;
                hold_user <= s.tuser;
            end
        end else if (m_tready) begin
            // move the held word into the output slot
            m_tdata <= hold_data;
            m_tkeep <= hold_keep;
            m_tlast <= hold_last;
            m_tuser <= hold_user;
        end
    end

endmodule

//--- hdl/eth_axis_tx_64.sv
// Ethernet frame transmitter top level, 64-bit datapath
// header inserter feeding the output register stage
`timescale 1ns/10ps

module eth_axis_tx_64 (
    input  logic                          clk,
    input  logic                          rst,
    // header input
    input  logic                          hdr_valid,
    output logic                          hdr_ready,
    input  logic [eth_tx_pkg::MAC_W-1:0]  dest_mac,
    input  logic [eth_tx_pkg::MAC_W-1:0]  src_mac,
    input  logic [eth_tx_pkg::TYPE_W-1:0] eth_type,
    // payload input
    input  logic [eth_tx_pkg::DATA_W-1:0] s_tdata,
    input  logic [eth_tx_pkg::KEEP_W-1:0] s_tkeep,
    input  logic                          s_tvalid,
    output logic                          s_tready,
    input  logic                          s_tlast,
    input  logic                          s_tuser,
    // frame output
    output logic [eth_tx_pkg::DATA_W-1:0] m_tdata,
    output logic [eth_tx_pkg::KEEP_W-1:0] m_tkeep,
    output logic                          m_tvalid,
    input  logic                          m_tready,
    output logic                          m_tlast,
    output logic                          m_tuser,
    output logic                          busy
);

    axis_if link ();

    eth_hdr_insert i_eth_hdr_insert (
        .clk       (clk),
        .rst       (rst),
        .hdr_valid (hdr_valid),
        .hdr_ready (hdr_ready),
        .dest_mac  (dest_mac),
        .src_mac   (src_mac),
        .eth_type  (eth_type),
        .s_tdata   (s_tdata),
        .s_tkeep   (s_tkeep),
        .s_tvalid  (s_tvalid),
        .s_tready  (s_tready),
        .s_tlast   (s_tlast),
        .s_tuser   (s_tuser),
        .m         (link.src),
        .busy      (busy)
    );

    axis_out_reg i_axis_out_reg (
        .clk      (clk),
        .rst      (rst),
        .s        (link.snk),
        .m_tdata  (m_tdata),
        .m_tkeep  (m_tkeep),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready),
        .m_tlast  (m_tlast),
        .m_tuser  (m_tuser)
    );

endmodule

//--- hdl/eth_hdr_insert.sv
// Ethernet header inserter for a 64-bit payload stream
// header FSM, header store and payload lane realignment
`timescale 1ns/10ps

module eth_hdr_insert (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          hdr_valid,
    output logic                          hdr_ready,
    input  logic [eth_tx_pkg::MAC_W-1:0]  dest_mac,
    input  logic [eth_tx_pkg::MAC_W-1:0]  src_mac,
    input  logic [eth_tx_pkg::TYPE_W-1:0] eth_type,
    input  logic [eth_tx_pkg::DATA_W-1:0] s_tdata,
    input  logic [eth_tx_pkg::KEEP_W-1:0] s_tkeep,
    input  logic                          s_tvalid,
    output logic                          s_tready,
    input  logic                          s_tlast,
    input  logic                          s_tuser,
    axis_if.src                           m,
    output logic                          busy
);

    localparam logic [1:0] ST_IDLE     = 2'd0;
    localparam logic [1:0] ST_HDR      = 2'd1;
    localparam logic [1:0] ST_HDR_LAST = 2'd2;
    localparam logic [1:0] ST_PAYLOAD  = 2'd3;

    logic [1:0] state;
    logic [1:0] state_next;
    logic       hdr_ready_next;
    logic       s_tready_next;
    logic       store_hdr;
    logic       flush_save;
    logic       load_save;

    logic [eth_tx_pkg::HDR_BYTES*8-1:0] hdr_reg;
    logic [eth_tx_pkg::HDR_BYTES*8-1:0] hdr_cur;
    logic [eth_tx_pkg::DATA_W-1:0]      word0;
    logic [eth_tx_pkg::DATA_W-1:0]      word1;
    logic [eth_tx_pkg::KEEP_W-1:0]      keep1;

    // previous input word
    logic [eth_tx_pkg::DATA_W-1:0] save_data;
    logic [eth_tx_pkg::KEEP_W-1:0] save_keep;
    logic                          save_last;
    logic                          save_user;

    logic [2*eth_tx_pkg::DATA_W-1:0] pair_data;
    logic [2*eth_tx_pkg::KEEP_W-1:0] pair_keep;
    logic [eth_tx_pkg::DATA_W-1:0]   shift_data;
    logic [eth_tx_pkg::KEEP_W-1:0]   shift_keep;
    logic                            shift_valid;
    logic                            shift_last;
    logic                            shift_user;
    logic                            shift_in_ready;
    logic                            s_spill;
    logic                            extra;

    // payload realignment
    // output word = saved lanes 2..7 followed by current lanes 0..1
    always_comb begin
        s_spill = |(s_tkeep >> (2*eth_tx_pkg::KEEP_W - eth_tx_pkg::HDR_BYTES));
        extra = save_last && |(save_keep >> (2*eth_tx_pkg::KEEP_W - eth_tx_pkg::HDR_BYTES));
        if (extra) begin
            // trailing word from the saved lanes only
            pair_data = {{eth_tx_pkg::DATA_W{1'b0}}, save_data};
            pair_keep = {{eth_tx_pkg::KEEP_W{1'b0}}, save_keep};
            shift_valid = 1'b1;
            shift_last = 1'b1;
            shift_user = save_user;
            shift_in_ready = 1'b0;
        end else begin
            pair_data = {s_tdata, save_data};
            pair_keep = {s_tkeep, save_keep};
            shift_valid = s_tvalid && s_tready;
            shift_last = s_tlast && !s_spill;
            shift_user = s_tuser && !s_spill;
            shift_in_ready = !(s_tlast && s_tvalid && s_tready);
        end
        shift_data = pair_data[(2*eth_tx_pkg::KEEP_W - eth_tx_pkg::HDR_BYTES)*8 +: eth_tx_pkg::DATA_W];
        shift_keep = pair_keep[(2*eth_tx_pkg::KEEP_W - eth_tx_pkg::HDR_BYTES) +: eth_tx_pkg::KEEP_W];
    end

    // header words, octet 0 of the header in lane 0
    always_comb begin
        hdr_cur = (state == ST_IDLE) ? {dest_mac, src_mac, eth_type} : hdr_reg;
        for (int i = 0; i < eth_tx_pkg::KEEP_W; i++) begin
            word0[8*i +: 8] = hdr_cur[eth_tx_pkg::HDR_BYTES*8-1-8*i -: 8];
            if (eth_tx_pkg::KEEP_W + i < eth_tx_pkg::HDR_BYTES) begin
                word1[8*i +: 8] =
                    hdr_cur[eth_tx_pkg::HDR_BYTES*8-1-8*(eth_tx_pkg::KEEP_W+i) -: 8];
                keep1[i] = 1'b1;
            end else begin
                word1[8*i +: 8] = shift_data[8*i +: 8];
                keep1[i] = shift_keep[i];
            end
        end
    end

    always_comb begin
        state_next = state;
        hdr_ready_next = 1'b0;
        s_tready_next = 1'b0;
        store_hdr = 1'b0;
        flush_save = 1'b0;
        load_save = 1'b0;
        m.tdata = '0;
        m.tkeep = '0;
        m.tvalid = 1'b0;
        m.tlast = 1'b0;
        m.tuser = 1'b0;
        case (state)
            ST_IDLE: begin
                flush_save = 1'b1;
                hdr_ready_next = 1'b1;
                if (hdr_valid && hdr_ready) begin
                    store_hdr = 1'b1;
                    hdr_ready_next = 1'b0;
                    state_next = ST_HDR;
                    // first header word goes straight out when possible
                    if (m.tready) begin
                        m.tvalid = 1'b1;
                        m.tdata = word0;
                        m.tkeep = '1;
                        s_tready_next = m.tready_early;
                        state_next = ST_HDR_LAST;
                    end
                end
            end
            ST_HDR: begin
                if (m.tready) begin
                    m.tvalid = 1'b1;
                    m.tdata = word0;
                    m.tkeep = '1;
                    s_tready_next = m.tready_early && shift_in_ready;
                    state_next = ST_HDR_LAST;
                end
            end
            default: begin
                // ST_HDR_LAST and ST_PAYLOAD both need a payload word
                s_tready_next = m.tready_early && shift_in_ready;
                if (m.tready && shift_valid) begin
                    m.tvalid = 1'b1;
                    m.tdata = (state == ST_HDR_LAST) ? word1 : shift_data;
                    m.tkeep = (state == ST_HDR_LAST) ? keep1 : shift_keep;
                    m.tlast = shift_last;
                    m.tuser = shift_user;
                    load_save = 1'b1;
                    state_next = ST_PAYLOAD;
                    if (shift_last) begin
                        s_tready_next = 1'b0;
                        flush_save = 1'b1;
                        hdr_ready_next = 1'b1;
                        state_next = ST_IDLE;
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
            hdr_ready <= 1'b0;
            s_tready <= 1'b0;
            busy <= 1'b0;
            save_keep <= '0;
            save_last <= 1'b0;
            save_user <= 1'b0;
        end else begin
            state <= state_next;
            hdr_ready <= hdr_ready_next;
            s_tready <= s_tready_next;
            busy <= (state_next != ST_IDLE);
            if (flush_save) begin
                save_keep <= '0;
                save_last <= 1'b0;
                save_user <= 1'b0;
            end else if (load_save) begin
                save_keep <= s_tkeep;
                save_last <= s_tlast;
                save_user <= s_tuser;
            end
        end
    end

    // header fields and saved payload data
    always_ff @(posedge clk) begin
        if (store_hdr) begin
            hdr_reg <= {dest_mac, src_mac, eth_type};
        end
        if (load_save) begin
            save_data <= s_tdata;
        end
    end

endmodule

//--- hdl/eth_tx_pkg.sv
// shared constants for the 64-bit Ethernet frame transmitter
// stream widths, header field widths and header length

package eth_tx_pkg;

    // stream word and byte enable widths
    localparam int DATA_W = 64;
    localparam int KEEP_W = 8;

    // header field widths
    localparam int MAC_W  = 48;
    localparam int TYPE_W = 16;

    // destination MAC, source MAC and Ethertype octets
    localparam int HDR_BYTES = 14;

endpackage

//--- verification/eth_axis_tx_64_checker.sv
// protocol assertions on the transmitter output stream
`timescale 1ns/10ps

module eth_axis_tx_64_checker (
    input logic                          clk,
    input logic                          rst,
    input logic [eth_tx_pkg::DATA_W-1:0] m_tdata,
    input logic [eth_tx_pkg::KEEP_W-1:0] m_tkeep,
    input logic                          m_tvalid,
    input logic                          m_tready,
    input logic                          m_tlast,
    input logic                          m_tuser
);

    int unsigned fail_count = 0;

    // word held until the sink takes it
    hold_check: assert property (@(posedge clk) disable iff (rst)
        m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tkeep) &&
            $stable(m_tlast) && $stable(m_tuser))
    else begin
        $error("output word changed while stalled");
        fail_count++;
    end

    // lanes filled from lane 0 upward
    keep_check: assert property (@(posedge clk) disable iff (rst)
        m_tvalid |-> (m_tkeep != 0) && ((m_tkeep & (m_tkeep + 8'd1)) == 0))
    else begin
        $error("tkeep empty or not contiguous");
        fail_count++;
    end

    full_check: assert property (@(posedge clk) disable iff (rst)
        m_tvalid && !m_tlast |-> m_tkeep == '1)
    else begin
        $error("partial tkeep on a word without tlast");
        fail_count++;
    end

    reset_check: assert property (@(posedge clk) rst |-> !m_tvalid)
    else begin
        $error("tvalid high during reset");
        fail_count++;
    end

endmodule

//--- verification/eth_axis_tx_64_tb.sv
// testbench for the 64-bit Ethernet frame transmitter
// random frames and back-pressure, byte-level model and scoreboard
`timescale 1ns/10ps

module eth_axis_tx_64_tb;

    localparam int NUM_FRAMES = 40;
    localparam int MAX_LEN = 64;
    localparam int MAX_WORDS = 12;
    localparam int CYCLES_PER_WORD = 8;
    localparam int RESET_CYCLES = 16;
    localparam int SEED = 12245;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * MAX_WORDS * CYCLES_PER_WORD + RESET_CYCLES;

    logic                          clk;
    logic                          rst;
    logic                          hdr_valid;
    logic                          hdr_ready;
    logic [eth_tx_pkg::MAC_W-1:0]  dest_mac;
    logic [eth_tx_pkg::MAC_W-1:0]  src_mac;
    logic [eth_tx_pkg::TYPE_W-1:0] eth_type;
    logic [eth_tx_pkg::DATA_W-1:0] s_tdata;
    logic [eth_tx_pkg::KEEP_W-1:0] s_tkeep;
    logic                          s_tvalid;
    logic                          s_tready;
    logic                          s_tlast;
    logic                          s_tuser;
    logic [eth_tx_pkg::DATA_W-1:0] m_tdata;
    logic [eth_tx_pkg::KEEP_W-1:0] m_tkeep;
    logic                          m_tvalid;
    logic                          m_tready;
    logic                          m_tlast;
    logic                          m_tuser;
    logic                          busy;

    // model queues, one octet or one frame per entry
    logic [7:0] exp_q[$];
    int         exp_words_q[$];
    logic [7:0] exp_keep_q[$];
    logic       exp_user_q[$];
    int         out_word_cnt = 0;
    int         frames_done = 0;
    int         cycle_cnt = 0;

    // sink ready per cycle
    logic       ready_pattern[TIMEOUT_CYCLES + 1];

    tb_clk_gen i_tb_clk_gen (.clk(clk));

    eth_axis_tx_64 i_eth_axis_tx_64 (.*);

    bind eth_axis_tx_64 eth_axis_tx_64_checker i_out_checker (
        .clk      (clk),
        .rst      (rst),
        .m_tdata  (m_tdata),
        .m_tkeep  (m_tkeep),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready),
        .m_tlast  (m_tlast),
        .m_tuser  (m_tuser)
    );

    task automatic stop_with_failure();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what);
        $display("Mismatch at %0t: %s", $time, what);
        stop_with_failure();
    endtask

    // one frame: model update, header handshake, payload words with gaps
    task automatic send_frame(input int idx);
        logic [7:0] payload [MAX_LEN];
        int         len;
        int         nwords;
        int         fill;
        logic       user;
        len = $urandom_range(MAX_LEN, 1);
        user = 1'($urandom());
        dest_mac = {16'($urandom()), $urandom()};
        src_mac = {16'($urandom()), $urandom()};
        eth_type = 16'($urandom());
        for (int i = 5; i >= 0; i--) begin
            exp_q.push_back(dest_mac[8*i +: 8]);
        end
        for (int i = 5; i >= 0; i--) begin
            exp_q.push_back(src_mac[8*i +: 8]);
        end
        exp_q.push_back(eth_type[15:8]);
        exp_q.push_back(eth_type[7:0]);
        for (int i = 0; i < len; i++) begin
            payload[i] = 8'($urandom());
            exp_q.push_back(payload[i]);
        end
        fill = ((eth_tx_pkg::HDR_BYTES + len - 1) % 8) + 1;
        exp_words_q.push_back((eth_tx_pkg::HDR_BYTES + len + 7) / 8);
        exp_keep_q.push_back(8'hff >> (8 - fill));
        exp_user_q.push_back(user);

        hdr_valid = 1'b1;
        do begin
            @(posedge clk);
        end while (!hdr_ready);
        @(negedge clk);
        hdr_valid = 1'b0;
        assert (busy) else report_mismatch($sformatf("frame %0d busy low after header", idx));

        nwords = (len + 7) / 8;
        for (int w = 0; w < nwords; w++) begin
            while ($urandom_range(3, 0) == 0) begin
                s_tvalid = 1'b0;
                @(negedge clk);
            end
            s_tdata = '0;
            s_tkeep = '0;
            for (int b = 0; b < 8; b++) begin
                if (8*w + b < len) begin
                    s_tdata[8*b +: 8] = payload[8*w + b];
                    s_tkeep[b] = 1'b1;
                end
            end
            s_tlast = (w == nwords - 1);
            s_tuser = s_tlast ? user : 1'b0;
            s_tvalid = 1'b1;
            do begin
                @(posedge clk);
            end while (!s_tready);
            @(negedge clk);
        end
        s_tvalid = 1'b0;
        s_tlast = 1'b0;
        s_tuser = 1'b0;
    endtask

    // scoreboard for one transferred output word
    task automatic check_output_word();
        int         total_words;
        logic       want_last;
        logic [7:0] want_keep;
        logic [7:0] want_byte;
        if (exp_words_q.size() == 0) begin
            $display("Output word at %0t with no frame outstanding", $time);
            stop_with_failure();
        end
        total_words = exp_words_q[0];
        out_word_cnt++;
        want_last = (out_word_cnt == total_words);
        want_keep = want_last ? exp_keep_q[0] : 8'hff;
        assert (m_tlast == want_last) else report_mismatch($sformatf(
            "frame %0d word %0d tlast %0b, expected %0b",
            frames_done, out_word_cnt, m_tlast, want_last));
        assert (m_tkeep == want_keep) else report_mismatch($sformatf(
            "frame %0d word %0d tkeep %h, expected %h",
            frames_done, out_word_cnt, m_tkeep, want_keep));
        for (int lane = 0; lane < 8; lane++) begin
            if (m_tkeep[lane]) begin
                want_byte = exp_q.pop_front();
                assert (m_tdata[8*lane +: 8] == want_byte) else report_mismatch($sformatf(
                    "frame %0d word %0d lane %0d octet %h, expected %h",
                    frames_done, out_word_cnt, lane, m_tdata[8*lane +: 8], want_byte));
            end
        end
        if (want_last) begin
            assert (m_tuser == exp_user_q[0]) else report_mismatch($sformatf(
                "frame %0d tuser %0b, expected %0b", frames_done, m_tuser, exp_user_q[0]));
            void'(exp_words_q.pop_front());
            void'(exp_keep_q.pop_front());
            void'(exp_user_q.pop_front());
            out_word_cnt = 0;
            frames_done++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst && m_tvalid && m_tready) begin
            check_output_word();
        end
    end

    // random sink back-pressure
    always @(negedge clk) begin
        m_tready = ready_pattern[cycle_cnt];
    end

    // protocol assertion failures from the bound checker
    always @(negedge clk) begin
        if (i_eth_axis_tx_64.i_out_checker.fail_count != 0) begin
            $display("Protocol assertion failed on the output stream at %0t", $time);
            stop_with_failure();
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d of %0d frames received",
                     cycle_cnt, frames_done, NUM_FRAMES);
            stop_with_failure();
        end
    end

    initial begin
        rst = 1'b1;
        hdr_valid = 1'b0;
        dest_mac = '0;
        src_mac = '0;
        eth_type = '0;
        s_tdata = '0;
        s_tkeep = '0;
        s_tvalid = 1'b0;
        s_tlast = 1'b0;
        s_tuser = 1'b0;
        m_tready = 1'b0;
        void'($urandom(SEED));
        for (int i = 0; i <= TIMEOUT_CYCLES; i++) begin
            ready_pattern[i] = ($urandom_range(3, 0) != 0);
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        assert (!m_tvalid && !busy && !hdr_ready)
            else report_mismatch("outputs active during reset");
        rst = 1'b0;
        @(negedge clk);
        assert (hdr_ready && !m_tvalid && !busy)
            else report_mismatch("hdr_ready not raised one cycle after reset");
        for (int f = 0; f < NUM_FRAMES; f++) begin
            send_frame(f);
        end
        while (frames_done < NUM_FRAMES) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        assert (!busy && !m_tvalid && hdr_ready)
            else report_mismatch("DUT not idle after the last frame");
        if (exp_q.size() == 0 && i_eth_axis_tx_64.i_out_checker.fail_count == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("%0d octets never sent, %0d protocol assertion failures",
                     exp_q.size(), i_eth_axis_tx_64.i_out_checker.fail_count);
            stop_with_failure();
        end
    end

endmodule

//--- verification/tb_clk_gen.sv
// free-running testbench clock, 100 ns period
`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

endmodule
